//--- verilog/wrcal_pkg.sv
// write calibrator shared widths, default training word and sequencer states
package wrcal_pkg;

  // -------------------------------------------------------------------------
  // data path widths
  // -------------------------------------------------------------------------

  // one byte per lane per beat
  localparam int BYTE_W      = 8;
  localparam int BURST_BEATS = 8;
  localparam int WORD_W      = BYTE_W * BURST_BEATS;

  // per-lane write delay code
  localparam int OFFSET_W    = 3;
  localparam int LANE_IDX_W  = 4;
  localparam int APB_ADDR_W  = 16;
  localparam int PASS_CNT_W  = 8;

  // training word before rotation
  localparam logic [63:0] DEFAULT_PATTERN = 64'h6644_99FF_AACC_3355;

  // -------------------------------------------------------------------------
  // sequencer states
  // -------------------------------------------------------------------------

  typedef enum logic [3:0] {
    WAIT_CTRLR_READY = 4'd0,
    WR_WAIT_BUS      = 4'd1,
    WR_REQ           = 4'd2,
    WR_WAIT_DREQ     = 4'd3,
    WR_DATA          = 4'd4,
    SETTLE           = 4'd5,
    RD_WAIT_BUS      = 4'd6,
    RD_REQ           = 4'd7,
    RD_WAIT_VALID    = 4'd8,
    CHECK_BUS_IDLE   = 4'd9,
    CHECK            = 4'd10,
    ADD_OFFSET       = 4'd11,
    NEXT_LANE        = 4'd12,
    DONE             = 4'd13
  } wrcal_state_e;

endpackage

//--- verilog/wrcal_fsm.sv
// calibration sequencer, steps each lane through write, settle, read and check
`timescale 1ns/1ps

module wrcal_fsm #(
  parameter int NUM_LANES     = 9,
  parameter int SETTLE_CYCLES = 16
) (
  input  logic                             sclk,
  input  logic                             reset_n,
  input  logic                             dfi_ctrlr_ready,
  input  logic                             cal_l_busy,
  input  logic                             cal_l_d_req,
  input  logic                             cal_l_r_valid,
  input  logic [wrcal_pkg::PASS_CNT_W-1:0] write_counter_value,
  input  logic                             lane_match,
  output logic                             cal_l_w_req,
  output logic                             cal_l_r_req,
  output logic                             select,
  output logic                             write_calibration_done,
  output logic [wrcal_pkg::PASS_CNT_W-1:0] pass_count,
  output logic [wrcal_pkg::LANE_IDX_W-1:0] cur_lane,
  output logic                             incr_offset
);
  import wrcal_pkg::*;

  localparam int                    SETTLE_W    = $clog2(SETTLE_CYCLES + 1);
  localparam logic [SETTLE_W-1:0]   SETTLE_LOAD = SETTLE_W'(SETTLE_CYCLES - 1);
  localparam logic [LANE_IDX_W-1:0] LAST_LANE   = LANE_IDX_W'(NUM_LANES - 1);

  wrcal_state_e        state_q;
  wrcal_state_e        state_d;
  logic [SETTLE_W-1:0] settle_cnt;

  // -------------------------------------------------------------------------
  // next state
  // -------------------------------------------------------------------------

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      WAIT_CTRLR_READY:
        if (dfi_ctrlr_ready)
          state_d = WR_WAIT_BUS;
      WR_WAIT_BUS:
        if (!cal_l_busy)
          state_d = WR_REQ;
      // back off if the controller went busy again
      WR_REQ:
        state_d = cal_l_busy ? WR_WAIT_BUS : WR_WAIT_DREQ;
      WR_WAIT_DREQ:
        if (cal_l_d_req)
          state_d = WR_DATA;
      WR_DATA:
        state_d = SETTLE;
      SETTLE:
        if (settle_cnt == '0)
          state_d = RD_WAIT_BUS;
      RD_WAIT_BUS:
        if (!cal_l_busy)
          state_d = RD_REQ;
      RD_REQ:
        state_d = cal_l_busy ? RD_WAIT_BUS : RD_WAIT_VALID;
      RD_WAIT_VALID:
        if (cal_l_r_valid)
          state_d = CHECK_BUS_IDLE;
      CHECK_BUS_IDLE:
        if (!cal_l_busy)
          state_d = CHECK;
      CHECK:
      begin
        if (!lane_match)
          state_d = ADD_OFFSET;
        else if (pass_count == '0)
          state_d = NEXT_LANE;
        else
          state_d = WR_WAIT_BUS;
      end
      ADD_OFFSET:
        state_d = WR_WAIT_BUS;
      NEXT_LANE:
        state_d = (cur_lane == LAST_LANE) ? DONE : WR_WAIT_BUS;
      DONE:
        state_d = DONE;
      default:
        state_d = WAIT_CTRLR_READY;
    endcase
  end

  // -------------------------------------------------------------------------
  // state, counters and lane index
  // -------------------------------------------------------------------------

  always_ff @(posedge sclk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state_q    <= WAIT_CTRLR_READY;
      settle_cnt <= '0;
      pass_count <= '0;
      cur_lane   <= '0;
    end
    else
    begin
      state_q <= state_d;

      // settle window is SETTLE_CYCLES long
      if (state_q == WR_DATA)
        settle_cnt <= SETTLE_LOAD;
      else if (state_q == SETTLE && settle_cnt != '0)
        settle_cnt <= settle_cnt - 1'b1;

      // pass run restarts on start, on a mismatch and per lane
      if (state_q == WAIT_CTRLR_READY || state_q == ADD_OFFSET || state_q == NEXT_LANE)
        pass_count <= write_counter_value;
      else if (state_q == CHECK && lane_match && pass_count != '0)
        pass_count <= pass_count - 1'b1;

      if (state_q == NEXT_LANE && cur_lane != LAST_LANE)
        cur_lane <= cur_lane + 1'b1;
    end
  end

  // -------------------------------------------------------------------------
  // registered strobes to the controller and the offset bank
  // -------------------------------------------------------------------------

  always_ff @(posedge sclk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      cal_l_w_req            <= 1'b0;
      cal_l_r_req            <= 1'b0;
      incr_offset            <= 1'b0;
      select                 <= 1'b0;
      write_calibration_done <= 1'b0;
    end
    else
    begin
      cal_l_w_req            <= (state_q == WR_REQ) && !cal_l_busy;
      cal_l_r_req            <= (state_q == RD_REQ) && !cal_l_busy;
      incr_offset            <= (state_q == CHECK) && !lane_match;
      select                 <= (state_d != WAIT_CTRLR_READY) && (state_d != DONE);
      write_calibration_done <= (state_d == DONE);
    end
  end

  // -------------------------------------------------------------------------
  // checks
  // -------------------------------------------------------------------------

  // write and read are issued one at a time
  a_req_exclusive: assert property (@(posedge sclk) disable iff (!reset_n)
    !(cal_l_w_req && cal_l_r_req));

  // controller was idle in the cycle a request was decided
  a_req_not_busy: assert property (@(posedge sclk) disable iff (!reset_n)
    (cal_l_w_req || cal_l_r_req) |-> !$past(cal_l_busy));

endmodule

//--- verilog/wrcal_pattern_gen.sv
// training pattern source, rotates the word per pass and drives the write bus
`timescale 1ns/1ps

module wrcal_pattern_gen #(
  parameter int                           NUM_LANES   = 9,
  parameter logic [wrcal_pkg::WORD_W-1:0] CAL_PATTERN = wrcal_pkg::DEFAULT_PATTERN
) (
  input  logic                                  sclk,
  input  logic                                  reset_n,
  input  logic [wrcal_pkg::PASS_CNT_W-1:0]      pass_count,
  output logic [wrcal_pkg::WORD_W-1:0]          expected_word,
  output logic [NUM_LANES*wrcal_pkg::WORD_W-1:0] cal_l_datain
);
  import wrcal_pkg::*;

  localparam int ROT_W = $clog2(BURST_BEATS);

  logic [ROT_W-1:0]            rot_sel;
  logic [2*WORD_W-1:0]         rot_dbl;
  logic [NUM_LANES*WORD_W-1:0] datain_d;

  // -------------------------------------------------------------------------
  // byte rotation
  // -------------------------------------------------------------------------

  // rotation step wraps every burst
  assign rot_sel = pass_count[ROT_W-1:0];

  // doubled word, upper half holds the rotate-left result
  assign rot_dbl       = {CAL_PATTERN, CAL_PATTERN} << (rot_sel * BYTE_W);
  assign expected_word = rot_dbl[2*WORD_W-1 -: WORD_W];

  // -------------------------------------------------------------------------
  // bus layout
  // -------------------------------------------------------------------------

  // beat b carries byte b of the word on every lane
  always_comb
  begin
    for (int b = 0; b < BURST_BEATS; b++)
    begin
      for (int i = 0; i < NUM_LANES; i++)
      begin
        datain_d[(b*NUM_LANES + i)*BYTE_W +: BYTE_W] = expected_word[b*BYTE_W +: BYTE_W];
      end
    end
  end

  always_ff @(posedge sclk or negedge reset_n)
  begin
    if (!reset_n)
      cal_l_datain <= '0;
    else
      cal_l_datain <= datain_d;
  end

endmodule

//--- verilog/wrcal_lane_check.sv
// readback checker, gathers the current lane from the read bus and compares it
`timescale 1ns/1ps

module wrcal_lane_check #(
  parameter int NUM_LANES = 9
) (
  input  logic                                   sclk,
  input  logic                                   reset_n,
  input  logic [NUM_LANES*wrcal_pkg::WORD_W-1:0] cal_l_dataout,
  input  logic                                   cal_l_r_valid,
  input  logic [wrcal_pkg::LANE_IDX_W-1:0]       cur_lane,
  input  logic [wrcal_pkg::WORD_W-1:0]           expected_word,
  output logic                                   lane_match
);
  import wrcal_pkg::*;

  localparam logic [LANE_IDX_W-1:0] LANE_LIMIT = LANE_IDX_W'(NUM_LANES);

  logic [WORD_W-1:0] lane_words [NUM_LANES];
  logic [WORD_W-1:0] sel_word;

  // -------------------------------------------------------------------------
  // per-lane word assembly
  // -------------------------------------------------------------------------

  // byte b of lane i sits at (b*NUM_LANES + i) bytes into the bus
  always_comb
  begin
    for (int i = 0; i < NUM_LANES; i++)
    begin
      for (int b = 0; b < BURST_BEATS; b++)
      begin
        lane_words[i][b*BYTE_W +: BYTE_W] = cal_l_dataout[(b*NUM_LANES + i)*BYTE_W +: BYTE_W];
      end
    end
  end

  // lane select, unused indexes give zero
  always_comb
  begin
    sel_word = '0;
    for (int i = 0; i < NUM_LANES; i++)
    begin
      if (cur_lane == LANE_IDX_W'(i))
        sel_word = lane_words[i];
    end
  end

  // -------------------------------------------------------------------------
  // match capture
  // -------------------------------------------------------------------------

  always_ff @(posedge sclk or negedge reset_n)
  begin
    if (!reset_n)
      lane_match <= 1'b0;
    else if (cal_l_r_valid)
      lane_match <= (sel_word == expected_word);
  end

  // sequencer never walks past the last lane
  a_lane_in_range: assert property (@(posedge sclk) disable iff (!reset_n)
    cur_lane < LANE_LIMIT);

endmodule

//--- verilog/wrcal_offset_regs.sv
// write offset bank, one wrapping delay code per lane with byte readback
`timescale 1ns/1ps

module wrcal_offset_regs #(
  parameter int NUM_LANES = 9
) (
  input  logic                                     sclk,
  input  logic                                     reset_n,
  input  logic                                     incr_offset,
  input  logic [wrcal_pkg::LANE_IDX_W-1:0]         cur_lane,
  input  logic [wrcal_pkg::APB_ADDR_W-1:0]         apb_addr,
  output logic [NUM_LANES*wrcal_pkg::OFFSET_W-1:0] write_calibration_offset,
  output logic [7:0]                               wrcal_rddata
);
  import wrcal_pkg::*;

  logic [OFFSET_W-1:0]   offset_q [NUM_LANES];
  logic [LANE_IDX_W-1:0] rd_lane;
  logic [OFFSET_W-1:0]   rd_offset;

  // -------------------------------------------------------------------------
  // offset registers
  // -------------------------------------------------------------------------

  always_ff @(posedge sclk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      for (int i = 0; i < NUM_LANES; i++)
        offset_q[i] <= '0;
    end
    else if (incr_offset)
    begin
      // 3-bit code wraps from 7 back to 0
      for (int i = 0; i < NUM_LANES; i++)
      begin
        if (cur_lane == LANE_IDX_W'(i))
          offset_q[i] <= offset_q[i] + 1'b1;
      end
    end
  end

  always_comb
  begin
    for (int i = 0; i < NUM_LANES; i++)
      write_calibration_offset[i*OFFSET_W +: OFFSET_W] = offset_q[i];
  end

  // -------------------------------------------------------------------------
  // register readback
  // -------------------------------------------------------------------------

  assign rd_lane = apb_addr[LANE_IDX_W-1:0];

  // addresses past the last lane fall back to lane 0
  always_comb
  begin
    rd_offset = offset_q[0];
    for (int i = 1; i < NUM_LANES; i++)
    begin
      if (rd_lane == LANE_IDX_W'(i))
        rd_offset = offset_q[i];
    end
  end

  assign wrcal_rddata = {{(8-OFFSET_W){1'b0}}, rd_offset};

endmodule

//--- verilog/wrcal_top.sv
// write calibrator top level, joins sequencer, pattern source, checker and offsets
`timescale 1ns/1ps

module wrcal_top #(
  parameter int                               NUM_LANES     = 9,
  parameter logic [wrcal_pkg::WORD_W-1:0]     CAL_PATTERN   = wrcal_pkg::DEFAULT_PATTERN,
  parameter int                               SETTLE_CYCLES = 16
) (
  input  logic                                sclk,
  input  logic                                reset_n,
  input  logic                                dfi_ctrlr_ready,
  input  logic                                cal_l_busy,
  input  logic                                cal_l_d_req,
  input  logic                                cal_l_r_valid,
  input  logic [NUM_LANES*wrcal_pkg::WORD_W-1:0]   cal_l_dataout,
  input  logic [wrcal_pkg::APB_ADDR_W-1:0]    apb_addr,
  input  logic [wrcal_pkg::PASS_CNT_W-1:0]    write_counter_value,
  output logic                                cal_l_w_req,
  output logic                                cal_l_r_req,
  output logic [NUM_LANES*wrcal_pkg::WORD_W-1:0]   cal_l_datain,
  output logic [NUM_LANES*wrcal_pkg::OFFSET_W-1:0] write_calibration_offset,
  output logic                                select,
  output logic                                write_calibration_done,
  output logic [7:0]                          wrcal_rddata
);
  import wrcal_pkg::*;

  logic [PASS_CNT_W-1:0] pass_count;
  logic [LANE_IDX_W-1:0] cur_lane;
  logic                  incr_offset;
  logic [WORD_W-1:0]     expected_word;
  logic                  lane_match;

  // -------------------------------------------------------------------------
  // sequencer
  // -------------------------------------------------------------------------

  wrcal_fsm #(
    .NUM_LANES              (NUM_LANES),
    .SETTLE_CYCLES          (SETTLE_CYCLES)
  ) i_fsm (
    .sclk                   (sclk),
    .reset_n                (reset_n),
    .dfi_ctrlr_ready        (dfi_ctrlr_ready),
    .cal_l_busy             (cal_l_busy),
    .cal_l_d_req            (cal_l_d_req),
    .cal_l_r_valid          (cal_l_r_valid),
    .write_counter_value    (write_counter_value),
    .lane_match             (lane_match),
    .cal_l_w_req            (cal_l_w_req),
    .cal_l_r_req            (cal_l_r_req),
    .select                 (select),
    .write_calibration_done (write_calibration_done),
    .pass_count             (pass_count),
    .cur_lane               (cur_lane),
    .incr_offset            (incr_offset)
  );

  // -------------------------------------------------------------------------
  // data path
  // -------------------------------------------------------------------------

  wrcal_pattern_gen #(
    .NUM_LANES     (NUM_LANES),
    .CAL_PATTERN   (CAL_PATTERN)
  ) i_pattern_gen (
    .sclk          (sclk),
    .reset_n       (reset_n),
    .pass_count    (pass_count),
    .expected_word (expected_word),
    .cal_l_datain  (cal_l_datain)
  );

  wrcal_lane_check #(
    .NUM_LANES     (NUM_LANES)
  ) i_lane_check (
    .sclk          (sclk),
    .reset_n       (reset_n),
    .cal_l_dataout (cal_l_dataout),
    .cal_l_r_valid (cal_l_r_valid),
    .cur_lane      (cur_lane),
    .expected_word (expected_word),
    .lane_match    (lane_match)
  );

  wrcal_offset_regs #(
    .NUM_LANES                (NUM_LANES)
  ) i_offset_regs (
    .sclk                     (sclk),
    .reset_n                  (reset_n),
    .incr_offset              (incr_offset),
    .cur_lane                 (cur_lane),
    .apb_addr                 (apb_addr),
    .write_calibration_offset (write_calibration_offset),
    .wrcal_rddata             (wrcal_rddata)
  );

endmodule

//--- tb/wrcal_ctrlr_model.sv
// behavioral DDR controller for calibration, per-lane write skew and random timing
`timescale 1ns/1ps

module wrcal_ctrlr_model #(
  parameter int          NUM_LANES = 9,
  parameter logic [31:0] SEED      = 32'h1
) (
  input  logic                                     sclk,
  input  logic                                     reset_n,
  input  logic                                     cal_l_w_req,
  input  logic                                     cal_l_r_req,
  input  logic [NUM_LANES*wrcal_pkg::WORD_W-1:0]   cal_l_datain,
  input  logic [NUM_LANES*wrcal_pkg::OFFSET_W-1:0] write_calibration_offset,
  output logic                                     cal_l_busy,
  output logic                                     cal_l_d_req,
  output logic                                     cal_l_r_valid,
  output logic [NUM_LANES*wrcal_pkg::WORD_W-1:0]   cal_l_dataout,
  output logic [NUM_LANES*wrcal_pkg::OFFSET_W-1:0] req_offset
);
  import wrcal_pkg::*;

  typedef enum logic [1:0] {M_IDLE, M_GAP, M_WRITE, M_READ} model_state_e;

  model_state_e                mstate;
  integer                      seed = SEED;
  int                          wait_cnt;
  logic [NUM_LANES*WORD_W-1:0] stored;

  function automatic int rand_range(input int lo, input int hi);
    int value;
    value = $random(seed) % (hi - lo + 1);
    if (value < 0)
      value = value + (hi - lo + 1);
    return lo + value;
  endfunction

  // lanes away from their required offset read back inverted
  function automatic logic [NUM_LANES*WORD_W-1:0] read_image(
    input logic [NUM_LANES*WORD_W-1:0] data
  );
    logic [NUM_LANES*WORD_W-1:0] img;
    img = data;
    for (int i = 0; i < NUM_LANES; i++)
    begin
      if (write_calibration_offset[i*OFFSET_W +: OFFSET_W] != req_offset[i*OFFSET_W +: OFFSET_W])
      begin
        for (int b = 0; b < BURST_BEATS; b++)
          img[(b*NUM_LANES + i)*BYTE_W +: BYTE_W] = ~data[(b*NUM_LANES + i)*BYTE_W +: BYTE_W];
      end
    end
    return img;
  endfunction

  always @(posedge sclk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      mstate        <= M_IDLE;
      wait_cnt      <= 0;
      cal_l_busy    <= 1'b0;
      cal_l_d_req   <= 1'b0;
      cal_l_r_valid <= 1'b0;
      cal_l_dataout <= '0;
      stored        <= '0;
      for (int i = 0; i < NUM_LANES; i++)
        req_offset[i*OFFSET_W +: OFFSET_W] <= OFFSET_W'(rand_range(0, 7));
    end
    else
    begin
      cal_l_d_req   <= 1'b0;
      cal_l_r_valid <= 1'b0;
      // burst data is taken in the d_req cycle
      if (cal_l_d_req)
        stored <= cal_l_datain;
      if (cal_l_w_req || cal_l_r_req)
      begin
        mstate     <= cal_l_w_req ? M_WRITE : M_READ;
        wait_cnt   <= rand_range(1, 6);
        cal_l_busy <= 1'b1;
      end
      else
      begin
        case (mstate)
          M_IDLE:
            if (rand_range(0, 3) == 0)
            begin
              mstate     <= M_GAP;
              wait_cnt   <= rand_range(1, 4);
              cal_l_busy <= 1'b1;
            end
          default:
            if (wait_cnt > 1)
              wait_cnt <= wait_cnt - 1;
            else
            begin
              mstate        <= M_IDLE;
              cal_l_busy    <= 1'b0;
              cal_l_d_req   <= (mstate == M_WRITE);
              cal_l_r_valid <= (mstate == M_READ);
              if (mstate == M_READ)
                cal_l_dataout <= read_image(stored);
            end
        endcase
      end
    end
  end

endmodule

//--- tb/tb_wrcal_top.sv
// testbench for the write calibrator, checks bursts, request order and final offsets
`timescale 1ns/1ps

module tb_wrcal_top;
  import wrcal_pkg::*;

  localparam int          NUM_LANES    = 9;
  localparam int          BUS_W        = NUM_LANES * WORD_W;
  localparam int          DONE_TIMEOUT = 50000;
  localparam logic [31:0] SEED         = 32'h83f9d79d;

  logic                            sclk;
  logic                            reset_n;
  logic                            dfi_ctrlr_ready;
  logic                            cal_l_busy;
  logic                            cal_l_d_req;
  logic                            cal_l_r_valid;
  logic [BUS_W-1:0]                cal_l_dataout;
  logic [APB_ADDR_W-1:0]           apb_addr;
  logic [PASS_CNT_W-1:0]           write_counter_value;
  logic                            cal_l_w_req;
  logic                            cal_l_r_req;
  logic [BUS_W-1:0]                cal_l_datain;
  logic [NUM_LANES*OFFSET_W-1:0]   write_calibration_offset;
  logic                            select;
  logic                            write_calibration_done;
  logic [7:0]                      wrcal_rddata;
  logic [NUM_LANES*OFFSET_W-1:0]   req_offset;

  // expected sequencer progress, tracked from the model's point of view
  logic prev_busy;
  logic expect_write;
  logic done_seen;
  int   track_pass;
  int   track_lane;
  int   track_offset [NUM_LANES];
  int   write_count [NUM_LANES];

  wrcal_top #(
    .NUM_LANES(NUM_LANES), .CAL_PATTERN(DEFAULT_PATTERN), .SETTLE_CYCLES(16)
  ) i_dut (.*);

  wrcal_ctrlr_model #(.NUM_LANES(NUM_LANES), .SEED(SEED)) i_ctrlr (.*);

  always #4 sclk = ~sclk;

  // -------------------------------------------------------------------------
  // reference functions
  // -------------------------------------------------------------------------

  function automatic logic [WORD_W-1:0] rotate_pattern(input logic [WORD_W-1:0] word,
                                                       input int bytes);
    logic [WORD_W-1:0] result;
    result = word;
    for (int k = 0; k < bytes; k++)
      result = {result[WORD_W-BYTE_W-1:0], result[WORD_W-1 -: BYTE_W]};
    return result;
  endfunction

  // byte b of the word on every lane of beat b
  function automatic logic [BUS_W-1:0] lane_layout(input logic [WORD_W-1:0] word);
    logic [BUS_W-1:0] bus;
    bus = '0;
    for (int b = 0; b < BURST_BEATS; b++)
      for (int i = 0; i < NUM_LANES; i++)
        bus[(b*NUM_LANES + i)*BYTE_W +: BYTE_W] = word[b*BYTE_W +: BYTE_W];
    return bus;
  endfunction

  function automatic int expected_writes(input int req, input int pass_load);
    return req + pass_load + 1;
  endfunction

  task automatic fail_value(input string msg);
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    $display("Checks failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic fail_timeout(input string what);
    $display("timed out while waiting for %s", what);
    $display("Checks failed");
    $fatal(1, "stopped on a timeout");
  endtask

  // -------------------------------------------------------------------------
  // monitor and compare
  // -------------------------------------------------------------------------

  task automatic check_write_burst();
    logic [BUS_W-1:0] exp_bus;
    int               req;
    assert (track_lane < NUM_LANES) else fail_value("write burst after the last lane");
    exp_bus = lane_layout(rotate_pattern(DEFAULT_PATTERN, track_pass % BURST_BEATS));
    assert (cal_l_datain == exp_bus)
      else fail_value($sformatf("write data wrong, lane %0d pass %0d", track_lane, track_pass));
    write_count[track_lane]++;
    req = int'(req_offset[track_lane*OFFSET_W +: OFFSET_W]);
    // this burst's readback decides the next step
    if (track_offset[track_lane] != req)
    begin
      track_offset[track_lane] = (track_offset[track_lane] + 1) % 8;
      track_pass = int'(write_counter_value);
    end
    else if (track_pass == 0)
    begin
      track_lane++;
      track_pass = int'(write_counter_value);
    end
    else
      track_pass--;
  endtask

  always @(posedge sclk)
  begin
    if (!reset_n)
    begin
      prev_busy    = 1'b0;
      expect_write = 1'b1;
      done_seen    = 1'b0;
      track_pass   = int'(write_counter_value);
      track_lane   = 0;
      for (int i = 0; i < NUM_LANES; i++)
      begin
        track_offset[i] = 0;
        write_count[i]  = 0;
      end
    end
    else
    begin
      if (!dfi_ctrlr_ready)
        assert (!write_calibration_done && !cal_l_w_req && !cal_l_r_req && !select)
          else fail_value("outputs active before controller ready");
      if (done_seen)
        assert (write_calibration_done) else fail_value("done dropped before reset");
      done_seen = done_seen || write_calibration_done;
      if (write_calibration_done)
        assert (!select) else fail_value("select still high with done");
      if (cal_l_w_req || cal_l_r_req)
        assert (select) else fail_value("request while select is low");
      if (cal_l_w_req || cal_l_r_req)
        assert (!prev_busy && !(cal_l_w_req && cal_l_r_req))
          else fail_value("request after a busy cycle or both requests at once");
      if (cal_l_w_req)
        assert (expect_write) else fail_value("write request without a read before it");
      if (cal_l_r_req)
        assert (!expect_write) else fail_value("read request without a write before it");
      if (cal_l_w_req || cal_l_r_req)
        expect_write = cal_l_r_req;
      if (cal_l_d_req)
        check_write_burst();
      prev_busy = cal_l_busy;
    end
  end

  // -------------------------------------------------------------------------
  // run sequence
  // -------------------------------------------------------------------------

  task automatic check_results(input int pass_load);
    int req;
    assert (track_lane == NUM_LANES) else fail_value("not every lane finished");
    for (int i = 0; i < NUM_LANES; i++)
    begin
      req = int'(req_offset[i*OFFSET_W +: OFFSET_W]);
      assert (int'(write_calibration_offset[i*OFFSET_W +: OFFSET_W]) == req)
        else fail_value($sformatf("lane %0d offset differs from required %0d", i, req));
      assert (write_count[i] == expected_writes(req, pass_load))
        else fail_value($sformatf("lane %0d got %0d writes", i, write_count[i]));
    end
    // register readback, address 12 falls back to lane 0
    for (int addr = 0; addr <= NUM_LANES; addr++)
    begin
      @(posedge sclk);
      apb_addr <= (addr == NUM_LANES) ? 16'd12 : APB_ADDR_W'(addr);
      @(posedge sclk);
      req = (addr == NUM_LANES) ? 0 : addr;
      assert (wrcal_rddata == 8'(req_offset[req*OFFSET_W +: OFFSET_W]))
        else fail_value($sformatf("readback wrong at address %0d", apb_addr));
    end
  endtask

  task automatic run_calibration(input logic [PASS_CNT_W-1:0] pass_load);
    int cycles;
    @(posedge sclk);
    reset_n             <= 1'b0;
    dfi_ctrlr_ready     <= 1'b0;
    write_counter_value <= pass_load;
    apb_addr            <= '0;
    repeat (8) @(posedge sclk);
    reset_n <= 1'b1;
    repeat (12) @(posedge sclk);
    dfi_ctrlr_ready <= 1'b1;
    cycles = 0;
    while (!write_calibration_done && cycles < DONE_TIMEOUT)
    begin
      @(posedge sclk);
      cycles++;
    end
    if (!write_calibration_done)
      fail_timeout("calibration done");
    // done must hold while the monitor keeps watching
    repeat (20) @(posedge sclk);
    check_results(int'(pass_load));
  endtask

  initial
  begin
    sclk                = 1'b0;
    reset_n             = 1'b0;
    dfi_ctrlr_ready     = 1'b0;
    apb_addr            = '0;
    write_counter_value = 8'd5;
    run_calibration(8'd5);
    run_calibration(8'd3);
    $display("All checks passed");
    $finish;
  end

endmodule

//--- project.f
verilog/wrcal_pkg.sv
verilog/wrcal_fsm.sv
verilog/wrcal_pattern_gen.sv
verilog/wrcal_lane_check.sv
verilog/wrcal_offset_regs.sv
verilog/wrcal_top.sv
tb/wrcal_ctrlr_model.sv
tb/tb_wrcal_top.sv

//--- run_sim.sh
#!/bin/sh
# build the write calibrator testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_wrcal_top \
  -f project.f -o Vtb_wrcal_top

status=0
./obj_dir/Vtb_wrcal_top > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Checks failed" sim.log || [ "$status" -ne 0 ]; then
  echo "simulation FAILED"
  exit 1
fi
echo "simulation passed"
